//--- Bender.yml
package:
  name: rps_matrix

sources:
  - source/rps_pkg.sv
  - source/round_judge.sv
  - source/side_renderer.sv
  - source/matrix_scanner.sv
  - source/rps_matrix_top.sv
  - target: test
    files:
      - test/rps_matrix_tb.sv

//--- rps_matrix.f
source/rps_pkg.sv
source/round_judge.sv
source/side_renderer.sv
source/matrix_scanner.sv
source/rps_matrix_top.sv
test/rps_matrix_tb.sv

//--- source/matrix_scanner.sv
/*
 * Row scan for the 8x8 matrix, one row per clk_1k tick.
 * Rows are driven active low and columns active high. All three outputs
 * are registered on the same edge, so a row and its columns always match.
 * Those outputs lag row_idx by one cycle.
 */

`default_nettype none

module matrix_scanner (
	input  logic                clk_1k,
	input  logic                rst,
	output rps_pkg::row_idx_t   row_idx,
	input  rps_pkg::half_cols_t red_halves [2],
	input  rps_pkg::half_cols_t green_halves [2],
	output rps_pkg::cols_t      col_r,
	output rps_pkg::cols_t      col_g,
	output rps_pkg::cols_t      row_o
);

	import rps_pkg::*;

	// ------------------------------------------------------------------------
	// row counter
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_1k or negedge rst)
	begin
		if (!rst)
			row_idx <= '0;
		else if (row_idx == row_idx_t'(MATRIX_ROWS - 1))
			row_idx <= '0;	// wrap to top
		else
			row_idx <= row_idx + row_idx_t'(1);
	end

	// ------------------------------------------------------------------------
	// output registers
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_1k or negedge rst)
	begin
		if (!rst)
		begin
			col_r <= '0;
			col_g <= '0;
			row_o <= '1;	// all rows off
		end
		else
		begin
			col_r <= {red_halves[1], red_halves[0]};	// side 0 low
			col_g <= {green_halves[1], green_halves[0]};
			row_o <= ~(cols_t'(1) << row_idx);
		end
	end

	// one row lit
	a_row_onehot: assert property (@(posedge clk_1k) disable iff (!rst)
		$past(rst) |-> $onehot(~row_o));

endmodule

`default_nettype wire

//--- source/round_judge.sv
/*
 * Round judge and scorekeeper.
 * hand_a and hand_b are level inputs sampled on clk_1k. play and ready are
 * single-cycle strobes, already debounced and synchronous to clk_1k.
 * A play needs both hands present and a match still running. Otherwise it
 * is dropped. A play on the same edge as ready takes priority.
 * The match state clears only on reset.
 */

`default_nettype none

module round_judge (
	input  logic                  clk_1k,
	input  logic                  rst,
	input  rps_pkg::hand_t        hand_a,
	input  rps_pkg::hand_t        hand_b,
	input  logic                  play,
	input  logic                  ready,
	output rps_pkg::hand_t        side_hand [2],
	output rps_pkg::side_result_t side_result [2],
	output logic                  match_over,
	output rps_pkg::score_t       score_a,
	output rps_pkg::score_t       score_b
);

	import rps_pkg::*;

	logic   accept;
	logic   a_wins;
	logic   b_wins;
	score_t score_a_nxt;
	score_t score_b_nxt;

	// rock > scissors > paper > rock
	function automatic logic beats(input hand_t x, input hand_t y);
		beats = ((x == HAND_ROCK)     && (y == HAND_SCISSORS)) ||
		        ((x == HAND_SCISSORS) && (y == HAND_PAPER))    ||
		        ((x == HAND_PAPER)    && (y == HAND_ROCK));
	endfunction

	// ------------------------------------------------------------------------
	// judging
	// ------------------------------------------------------------------------
	assign accept = play && !match_over && (hand_a != HAND_NONE) && (hand_b != HAND_NONE);
	assign a_wins = beats(hand_a, hand_b);
	assign b_wins = beats(hand_b, hand_a);

	always_comb
	begin
		score_a_nxt = score_a;
		score_b_nxt = score_b;
		if (a_wins)
			score_a_nxt = score_a + score_t'(1);
		if (b_wins)
			score_b_nxt = score_b + score_t'(1);
	end

	// ------------------------------------------------------------------------
	// state
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_1k or negedge rst)
	begin
		if (!rst)
		begin
			score_a        <= '0;
			score_b        <= '0;
			match_over     <= 1'b0;
			side_result[0] <= RES_BLANK;
			side_result[1] <= RES_BLANK;
		end
		else if (accept)
		begin
			score_a    <= score_a_nxt;
			score_b    <= score_b_nxt;
			match_over <= (score_a_nxt == WIN_SCORE) || (score_b_nxt == WIN_SCORE);
			if (a_wins)
			begin
				side_result[0] <= RES_WIN;
				side_result[1] <= RES_LOSE;
			end
			else if (b_wins)
			begin
				side_result[0] <= RES_LOSE;
				side_result[1] <= RES_WIN;
			end
			else
			begin
				side_result[0] <= RES_DRAW;
				side_result[1] <= RES_DRAW;
			end
		end
		else if (ready && !match_over)	// blank between rounds
		begin
			side_result[0] <= RES_BLANK;
			side_result[1] <= RES_BLANK;
		end
	end

	// latched hands for the renderers
	always_ff @(posedge clk_1k)
	begin
		if (accept)
		begin
			side_hand[0] <= hand_a;
			side_hand[1] <= hand_b;
		end
	end

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------
	// a score never wraps past three
	a_score_cap: assert property (@(posedge clk_1k) disable iff (!rst)
		(score_a >= $past(score_a)) && (score_b >= $past(score_b)));

	a_score_frozen: assert property (@(posedge clk_1k) disable iff (!rst)
		match_over |=> ($stable(score_a) && $stable(score_b)));

	a_single_winner: assert property (@(posedge clk_1k) disable iff (!rst)
		!((side_result[0] == RES_WIN) && (side_result[1] == RES_WIN)));

endmodule

`default_nettype wire

//--- source/rps_matrix_top.sv
/*
 * Rock-paper-scissors scoreboard on an 8x8 red/green LED matrix.
 * Everything runs on clk_1k. Inputs must be synchronous to it.
 * Player A shows in columns 0-3, player B in columns 4-7.
 */

`default_nettype none

module rps_matrix_top (
	input  logic            clk_1k,
	input  logic            rst,
	input  rps_pkg::hand_t  hand_a,
	input  rps_pkg::hand_t  hand_b,
	input  logic            play,
	input  logic            ready,
	output rps_pkg::cols_t  col_r,
	output rps_pkg::cols_t  col_g,
	output rps_pkg::cols_t  row_o,
	output rps_pkg::score_t score_a,
	output rps_pkg::score_t score_b
);

	import rps_pkg::*;

	hand_t        side_hand [2];
	side_result_t side_result [2];
	logic         match_over;
	row_idx_t     row_idx;
	half_cols_t   red_halves [2];
	half_cols_t   green_halves [2];

	round_judge round_judge_inst (
		.clk_1k      (clk_1k),
		.rst         (rst),
		.hand_a      (hand_a),
		.hand_b      (hand_b),
		.play        (play),
		.ready       (ready),
		.side_hand   (side_hand),
		.side_result (side_result),
		.match_over  (match_over),
		.score_a     (score_a),
		.score_b     (score_b)
	);

	// side 0 is player A
	for (genvar side = 0; side < 2; side++)
	begin : g_side
		side_renderer side_renderer_inst (
			.side_hand       (side_hand[side]),
			.side_result     (side_result[side]),
			.opponent_result (side_result[1-side]),
			.match_over      (match_over),
			.row_idx         (row_idx),
			.red             (red_halves[side]),
			.green           (green_halves[side])
		);
	end

	matrix_scanner matrix_scanner_inst (
		.clk_1k       (clk_1k),
		.rst          (rst),
		.row_idx      (row_idx),
		.red_halves   (red_halves),
		.green_halves (green_halves),
		.col_r        (col_r),
		.col_g        (col_g),
		.row_o        (row_o)
	);

endmodule

`default_nettype wire

//--- source/rps_pkg.sv
/*
 * Shared types and constants for the rock-paper-scissors scoreboard.
 * The matrix is 8x8 and two-coloured. Each player owns one 4-column half.
 * Bit 0 of a half is its leftmost column. Player A takes the low half.
 * A hand glyph uses rows 1 to 4 only. Rows 0, 5, 6 and 7 stay dark.
 * The match ends at WIN_SCORE. The score type is sized for exactly that.
 */

`default_nettype none

package rps_pkg;

	// ------------------------------------------------------------------------
	// matrix geometry
	// ------------------------------------------------------------------------
	localparam int unsigned MATRIX_ROWS = 8;
	localparam int unsigned HALF_COLS   = 4;

	typedef logic [$clog2(MATRIX_ROWS)-1:0] row_idx_t;	// scanned row
	typedef logic [HALF_COLS-1:0]           half_cols_t;	// one player's columns
	typedef logic [2*HALF_COLS-1:0]         cols_t;	// full column word

	// ------------------------------------------------------------------------
	// game encodings
	// ------------------------------------------------------------------------
	typedef enum logic [1:0]
	{
		HAND_NONE     = 2'd0,
		HAND_ROCK     = 2'd1,
		HAND_SCISSORS = 2'd2,
		HAND_PAPER    = 2'd3
	} hand_t;

	typedef enum logic [1:0]
	{
		RES_BLANK = 2'd0,	// display off between rounds
		RES_WIN   = 2'd1,
		RES_LOSE  = 2'd2,
		RES_DRAW  = 2'd3
	} side_result_t;

	typedef logic [1:0] score_t;

	localparam score_t WIN_SCORE = 2'd3;	// first to three

	// ------------------------------------------------------------------------
	// half-glyph table, indexed by hand value then row
	// ------------------------------------------------------------------------
	localparam half_cols_t GLYPH_ROM [1:3][MATRIX_ROWS] =
	'{
		// rock
		'{4'b0000, 4'b1111, 4'b1111, 4'b1111,
		  4'b1111, 4'b0000, 4'b0000, 4'b0000},
		// scissors
		'{4'b0000, 4'b1001, 4'b0110, 4'b0110,
		  4'b1001, 4'b0000, 4'b0000, 4'b0000},
		// paper
		'{4'b0000, 4'b0110, 4'b1111, 4'b1111,
		  4'b0110, 4'b0000, 4'b0000, 4'b0000}
	};

endpackage

`default_nettype wire

//--- source/side_renderer.sv
/*
 * One player's half of the matrix, purely combinational.
 * Winners and draws light green, a loss lights red, blank lights nothing.
 * At match end the glyph is dropped and the whole half shows the outcome.
 * The match winner is taken from the last round's results. That round is
 * always a win, since scores rise only on wins.
 */

`default_nettype none

module side_renderer (
	input  rps_pkg::hand_t        side_hand,
	input  rps_pkg::side_result_t side_result,
	input  rps_pkg::side_result_t opponent_result,
	input  logic                  match_over,
	input  rps_pkg::row_idx_t     row_idx,
	output rps_pkg::half_cols_t   red,
	output rps_pkg::half_cols_t   green
);

	import rps_pkg::*;

	half_cols_t glyph_row;
	logic       won_match;

	// ------------------------------------------------------------------------
	// glyph lookup
	// ------------------------------------------------------------------------
	always_comb
	begin
		glyph_row = '0;
		if (side_hand != HAND_NONE)
			glyph_row = GLYPH_ROM[side_hand][row_idx];
	end

	// decided by the final round
	assign won_match = (side_result == RES_WIN) && (opponent_result == RES_LOSE);

	// ------------------------------------------------------------------------
	// colour rule
	// ------------------------------------------------------------------------
	always_comb
	begin
		red   = '0;
		green = '0;
		if (match_over)
		begin
			if (won_match)
				green = '1;	// winner's half solid green
			else
				red = '1;
		end
		else
		begin
			case (side_result)
				RES_WIN,
				RES_DRAW:
				begin
					green = glyph_row;
				end
				RES_LOSE:
				begin
					red = glyph_row;
				end
				default:
				begin
					red   = '0;	// blank
					green = '0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- test/rps_matrix_tb.sv
/*
 * Testbench for the rock-paper-scissors matrix scoreboard.
 * A reference model built from the package tables predicts the registered
 * columns, row select and scores every cycle. Concurrent assertions compare
 * the DUT with it. Stimulus changes on the rising edge of clk_1k.
 * Random hands come from a fixed-seed LCG and never include HAND_NONE.
 */

`default_nettype none

module rps_matrix_tb;

	import rps_pkg::*;

	localparam int ROUND_LIMIT = 64;	// random rounds before giving up

	logic   clk_1k;
	logic   rst;
	hand_t  hand_a;
	hand_t  hand_b;
	logic   play;
	logic   ready;
	cols_t  col_r;
	cols_t  col_g;
	cols_t  row_o;
	score_t score_a;
	score_t score_b;

	// reference model state
	score_t       m_score [2];
	side_result_t m_res [2];
	hand_t        m_hand [2];
	logic         m_over;
	row_idx_t     m_row;
	cols_t        exp_col_r;
	cols_t        exp_col_g;
	cols_t        exp_row;

	string        test_name;
	logic [31:0]  seed;

	rps_matrix_top rps_matrix_top_inst (
		.clk_1k  (clk_1k),
		.rst     (rst),
		.hand_a  (hand_a),
		.hand_b  (hand_b),
		.play    (play),
		.ready   (ready),
		.col_r   (col_r),
		.col_g   (col_g),
		.row_o   (row_o),
		.score_a (score_a),
		.score_b (score_b)
	);

	initial clk_1k = 1'b0;
	always #2 clk_1k = ~clk_1k;

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------
	task automatic stop_run();
		$display("Verification failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_mismatch(input string what, input cols_t expected, input cols_t actual);
		$display("ERROR [%s] %s: expected %h, actual %h", test_name, what, expected, actual);
		stop_run();
	endtask

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic hand_t hand_from(input logic [31:0] s);
		case (s[23:16] % 3)
			0:       return HAND_ROCK;
			1:       return HAND_SCISSORS;
			default: return HAND_PAPER;
		endcase
	endfunction

	// 0 when a wins, 1 when b wins, -1 on a draw
	function automatic int round_winner(input hand_t a, input hand_t b);
		if (a == b)
			return -1;
		if (int'(b) == (int'(a) % 3) + 1)	// each hand beats the next one in order
			return 0;
		return 1;
	endfunction

	// {red, green} for one half at the model's current row
	function automatic logic [7:0] half_colours(input int side);
		half_cols_t glyph;
		glyph = '0;
		if (m_hand[side] != HAND_NONE)
			glyph = GLYPH_ROM[m_hand[side]][m_row];
		if (m_over)
			return (m_res[side] == RES_WIN) ? 8'h0f : 8'hf0;	// banner
		if (m_res[side] == RES_LOSE)
			return {glyph, 4'h0};
		if (m_res[side] == RES_BLANK)
			return 8'h00;
		return {4'h0, glyph};
	endfunction

	// ------------------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------------------
	always @(posedge clk_1k or negedge rst)
	begin : ref_model
		int         winner;
		logic [7:0] side_a;
		logic [7:0] side_b;
		score_t     next_a;
		score_t     next_b;
		cols_t      row_sel;
		if (!rst)
		begin
			m_score   <= '{2'd0, 2'd0};
			m_res     <= '{RES_BLANK, RES_BLANK};
			m_hand    <= '{HAND_NONE, HAND_NONE};
			m_over    <= 1'b0;
			m_row     <= '0;
			exp_col_r <= '0;
			exp_col_g <= '0;
			exp_row   <= '1;
		end
		else
		begin
			side_a = half_colours(0);
			side_b = half_colours(1);
			row_sel = '1;
			row_sel[m_row] = 1'b0;	// only the scanned row low
			exp_col_r <= {side_b[7:4], side_a[7:4]};
			exp_col_g <= {side_b[3:0], side_a[3:0]};
			exp_row   <= row_sel;
			m_row     <= (m_row == row_idx_t'(MATRIX_ROWS - 1)) ? '0 : m_row + 1'b1;
			if (play && !m_over && (hand_a != HAND_NONE) && (hand_b != HAND_NONE))
			begin
				winner = round_winner(hand_a, hand_b);
				next_a = m_score[0];
				next_b = m_score[1];
				if (winner == 0)
					next_a = next_a + 2'd1;
				if (winner == 1)
					next_b = next_b + 2'd1;
				m_score <= '{next_a, next_b};
				m_hand  <= '{hand_a, hand_b};
				m_over  <= (next_a == WIN_SCORE) || (next_b == WIN_SCORE);
				case (winner)
					0:       m_res <= '{RES_WIN, RES_LOSE};
					1:       m_res <= '{RES_LOSE, RES_WIN};
					default: m_res <= '{RES_DRAW, RES_DRAW};
				endcase
			end
			else if (ready && !m_over)
				m_res <= '{RES_BLANK, RES_BLANK};
		end
	end

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------
	a_col_r: assert property (@(posedge clk_1k) disable iff (!rst) col_r == exp_col_r)
		else report_mismatch("col_r", $sampled(exp_col_r), $sampled(col_r));

	a_col_g: assert property (@(posedge clk_1k) disable iff (!rst) col_g == exp_col_g)
		else report_mismatch("col_g", $sampled(exp_col_g), $sampled(col_g));

	a_row_o: assert property (@(posedge clk_1k) disable iff (!rst) row_o == exp_row)
		else report_mismatch("row_o", $sampled(exp_row), $sampled(row_o));

	a_score_a: assert property (@(posedge clk_1k) disable iff (!rst) score_a == m_score[0])
		else report_mismatch("score_a", $sampled(m_score[0]), $sampled(score_a));

	a_score_b: assert property (@(posedge clk_1k) disable iff (!rst) score_b == m_score[1])
		else report_mismatch("score_b", $sampled(m_score[1]), $sampled(score_b));

	// ------------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------------
	task automatic play_round(input hand_t a, input hand_t b);
		@(posedge clk_1k);
		hand_a <= a;
		hand_b <= b;
		play   <= 1'b1;
		@(posedge clk_1k);
		play   <= 1'b0;
	endtask

	task automatic strobe_ready();
		@(posedge clk_1k);
		ready <= 1'b1;
		@(posedge clk_1k);
		ready <= 1'b0;
	endtask

	// wait until every row has been selected once
	task automatic scan_frame();
		cols_t seen;
		int    cycles;
		seen   = '0;
		cycles = 0;
		while (seen != '1)
		begin
			if (cycles == 3 * MATRIX_ROWS)
			begin
				$display("row scan in %s did not reach all rows in time", test_name);
				stop_run();
			end
			else
			begin
				@(negedge clk_1k);
				seen = seen | ~row_o;
				cycles++;
			end
		end
	endtask

	initial
	begin
		int    rounds;
		hand_t ha;
		hand_t hb;
		rst       = 1'b0;
		hand_a    = HAND_NONE;
		hand_b    = HAND_NONE;
		play      = 1'b0;
		ready     = 1'b0;
		seed      = 32'hda35_1291;
		test_name = "reset";
		repeat (4) @(posedge clk_1k);
		rst <= 1'b1;
		scan_frame();
		scan_frame();	// wrap back through row 0

		test_name = "win";
		play_round(HAND_ROCK, HAND_SCISSORS);
		scan_frame();
		play_round(HAND_PAPER, HAND_SCISSORS);
		scan_frame();

		test_name = "draw";
		play_round(HAND_PAPER, HAND_PAPER);
		scan_frame();
		strobe_ready();
		scan_frame();

		test_name = "ignored";
		play_round(HAND_NONE, HAND_ROCK);
		scan_frame();
		play_round(HAND_SCISSORS, HAND_NONE);
		scan_frame();

		test_name = "match";
		rounds = 0;
		while (!m_over)
		begin
			if (rounds == ROUND_LIMIT)
			begin
				$display("no player reached %0d points in %0d rounds", WIN_SCORE, ROUND_LIMIT);
				stop_run();
			end
			else
			begin
				seed = lcg_next(seed);
				ha   = hand_from(seed);
				seed = lcg_next(seed);
				hb   = hand_from(seed);
				play_round(ha, hb);
				scan_frame();
				strobe_ready();
				rounds++;
			end
		end

		test_name = "banner";
		scan_frame();
		play_round(HAND_ROCK, HAND_PAPER);
		scan_frame();
		strobe_ready();
		play_round(HAND_SCISSORS, HAND_ROCK);
		scan_frame();

		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire
